// File: rfi_defines.svh
`ifndef RFI_DEFINES_SVH
`define RFI_DEFINES_SVH

// input lane width of the four sample streams.
`define RFI_DIN_WIDTH 18

// lane width after the input cast.
`define RFI_CAST_WIDTH 9

// right shift applied before the input cast.
`define RFI_CAST_SHIFT 9

// width of the per-channel running sums.
`define RFI_ACC_WIDTH 32

// right shift applied before the output cast.
`define RFI_DOUT_SHIFT 8

// width of the power and correlation outputs.
`define RFI_DOUT_WIDTH 16

// channels per spectrum and the index width that covers them.
`define RFI_CHANNELS 16
`define RFI_CHAN_BITS 4

`endif

// File: rfi_pkg.sv
`default_nettype none

`include "rfi_defines.svh"

package rfi_pkg;

    // one cast sample lane.
    typedef logic signed [`RFI_CAST_WIDTH-1:0] cast_t;

    // power is a sum of squares, so it never goes negative.
    typedef logic [`RFI_ACC_WIDTH-1:0] pow_t;

    // real part of the cross-correlation.
    typedef logic signed [`RFI_ACC_WIDTH-1:0] corr_t;

    // channel index within a spectrum.
    typedef logic [`RFI_CHAN_BITS-1:0] chan_t;

    // one sample's products, tagged with its place in the accumulation.
    typedef struct packed {
        chan_t chan;
        logic  first;
        logic  last;
        pow_t  pow;
        corr_t corr;
    } prod_t;

endpackage

`default_nettype wire

// File: rfi_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rfi_stream_if;
    import rfi_pkg::*;

    logic  valid;
    logic  sync;
    cast_t sig_re;
    cast_t sig_im;
    cast_t ref_re;
    cast_t ref_im;

    // cast stage drives the lanes.
    modport source (
        output valid,
        output sync,
        output sig_re,
        output sig_im,
        output ref_re,
        output ref_im
    );

    // product stage reads them, no back-pressure.
    modport sink (
        input valid,
        input sync,
        input sig_re,
        input sig_im,
        input ref_re,
        input ref_im
    );

endinterface

`default_nettype wire

// File: rfi_input_cast.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module rfi_input_cast (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire signed [`RFI_DIN_WIDTH-1:0] sig_re,
    input  wire signed [`RFI_DIN_WIDTH-1:0] sig_im,
    input  wire signed [`RFI_DIN_WIDTH-1:0] ref_re,
    input  wire signed [`RFI_DIN_WIDTH-1:0] ref_im,
    input  wire                             din_valid,
    input  wire                             sync_in,
    rfi_stream_if.source                    out,
    output logic                            in_sat
);
    import rfi_pkg::*;

    localparam int LANES = 4;
    localparam int CAST_MAX = (1 << (`RFI_CAST_WIDTH - 1)) - 1;
    localparam int CAST_MIN = -(1 << (`RFI_CAST_WIDTH - 1));

    logic signed [`RFI_DIN_WIDTH-1:0] lane_in [LANES];
    logic signed [`RFI_DIN_WIDTH-1:0] shifted [LANES];
    cast_t                            lane_cast [LANES];
    logic [LANES-1:0]                 lane_clip;

    // lane order is sig_re, sig_im, ref_re, ref_im.
    assign lane_in[0] = sig_re;
    assign lane_in[1] = sig_im;
    assign lane_in[2] = ref_re;
    assign lane_in[3] = ref_im;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            shifted[i] = lane_in[i] >>> `RFI_CAST_SHIFT;
            if (shifted[i] > CAST_MAX) begin
                lane_cast[i] = cast_t'(CAST_MAX);
                lane_clip[i] = 1'b1;
            end else if (shifted[i] < CAST_MIN) begin
                lane_cast[i] = cast_t'(CAST_MIN);
                lane_clip[i] = 1'b1;
            end else begin
                lane_cast[i] = shifted[i][`RFI_CAST_WIDTH-1:0];
                lane_clip[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.sync  <= 1'b0;
            in_sat    <= 1'b0;
        end else begin
            out.valid <= din_valid;
            out.sync  <= din_valid && sync_in;
            // only a clip on a real sample counts.
            in_sat    <= din_valid && (|lane_clip);
        end
    end

    always_ff @(posedge clk) begin
        out.sig_re <= lane_cast[0];
        out.sig_im <= lane_cast[1];
        out.ref_re <= lane_cast[2];
        out.ref_im <= lane_cast[3];
    end

endmodule

`default_nettype wire

// File: rfi_product.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module rfi_product (
    input  wire           clk,
    input  wire           rst_n,
    rfi_stream_if.sink    in,
    input  wire [31:0]    acc_len,
    input  wire           cnt_rst,
    output logic          prod_valid,
    output rfi_pkg::prod_t prod
);
    import rfi_pkg::*;

    chan_t       chan_q;
    logic [31:0] spec_q;
    logic [31:0] len_q;
    logic        seen_sync;

    chan_t       chan_c;
    logic [31:0] spec_c;
    logic [31:0] len_c;
    logic        take;

    logic signed [`RFI_ACC_WIDTH-1:0] sig_re_x;
    logic signed [`RFI_ACC_WIDTH-1:0] sig_im_x;
    logic signed [`RFI_ACC_WIDTH-1:0] ref_re_x;
    logic signed [`RFI_ACC_WIDTH-1:0] ref_im_x;
    pow_t                             pow_c;
    corr_t                            corr_c;

    // position of the incoming sample.
    always_comb begin
        chan_c = chan_q + 1'b1;
        spec_c = spec_q;
        len_c  = len_q;
        if (in.sync) begin
            chan_c = '0;
            if (!seen_sync || spec_q == len_q - 1) begin
                // new accumulation, a zero length counts as one spectrum.
                spec_c = '0;
                len_c  = (acc_len == '0) ? 32'd1 : acc_len;
            end else begin
                spec_c = spec_q + 1;
            end
        end
    end

    // nothing is taken until the first sync.
    assign take = in.valid && (seen_sync || in.sync);

    // widen before multiplying so the products keep every bit.
    assign sig_re_x = in.sig_re;
    assign sig_im_x = in.sig_im;
    assign ref_re_x = in.ref_re;
    assign ref_im_x = in.ref_im;

    assign pow_c  = pow_t'(ref_re_x * ref_re_x + ref_im_x * ref_im_x);
    assign corr_c = sig_re_x * ref_re_x + sig_im_x * ref_im_x;

    always_ff @(posedge clk) begin
        if (!rst_n || cnt_rst) begin
            chan_q    <= '0;
            spec_q    <= '0;
            len_q     <= '0;
            seen_sync <= 1'b0;
        end else if (take) begin
            chan_q    <= chan_c;
            spec_q    <= spec_c;
            len_q     <= len_c;
            seen_sync <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prod.chan  <= chan_c;
            prod.first <= (spec_c == '0);
            prod.last  <= (spec_c == len_c - 1);
            prod.pow   <= pow_c;
            prod.corr  <= corr_c;
        end
    end

endmodule

`default_nettype wire

// File: rfi_vector_acc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module rfi_vector_acc #(
    parameter type acc_t = rfi_pkg::pow_t
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             in_valid,
    input  rfi_pkg::chan_t  chan,
    input  wire             first,
    input  wire             last,
    input  acc_t            value,
    output logic            sum_valid,
    output acc_t            sum
);

    // one running sum per channel.
    acc_t mem [`RFI_CHANNELS];

    acc_t stored;
    acc_t next_sum;

    // read and write of one channel in the same cycle is safe, the next
    // sample for that channel is at least a full spectrum away.
    assign stored = mem[chan];

    // first spectrum starts a fresh sum.
    assign next_sum = first ? value : acc_t'(stored + value);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[chan] <= next_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= in_valid && last;
        end
    end

    // completed sum leaves in the last spectrum.
    always_ff @(posedge clk) begin
        if (in_valid && last) begin
            sum <= next_sum;
        end
    end

endmodule

`default_nettype wire

// File: rfi_output_cast.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module rfi_output_cast (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              cnt_rst,
    input  wire                              in_valid,
    input  rfi_pkg::pow_t                    pow_sum,
    input  rfi_pkg::corr_t                   corr_sum,
    input  wire                              in_sat,
    output logic [`RFI_DOUT_WIDTH-1:0]       pow_data,
    output logic [`RFI_DOUT_WIDTH-1:0]       corr_data,
    output logic                             dout_valid,
    output logic                             warning
);
    import rfi_pkg::*;

    localparam pow_t  POW_MAX  = pow_t'((1 << `RFI_DOUT_WIDTH) - 1);
    localparam corr_t CORR_MAX = corr_t'((1 << (`RFI_DOUT_WIDTH - 1)) - 1);
    localparam corr_t CORR_MIN = corr_t'(-(1 << (`RFI_DOUT_WIDTH - 1)));

    pow_t  pow_shift;
    corr_t corr_shift;
    pow_t  pow_sat;
    corr_t corr_sat;
    logic  pow_clip;
    logic  corr_clip;

    assign pow_shift  = pow_sum >> `RFI_DOUT_SHIFT;
    assign corr_shift = corr_sum >>> `RFI_DOUT_SHIFT;

    assign pow_clip = pow_shift > POW_MAX;
    assign pow_sat  = pow_clip ? POW_MAX : pow_shift;

    always_comb begin
        corr_clip = 1'b1;
        if (corr_shift > CORR_MAX) begin
            corr_sat = CORR_MAX;
        end else if (corr_shift < CORR_MIN) begin
            corr_sat = CORR_MIN;
        end else begin
            corr_sat  = corr_shift;
            corr_clip = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pow_data  <= pow_sat[`RFI_DOUT_WIDTH-1:0];
            corr_data <= corr_sat[`RFI_DOUT_WIDTH-1:0];
        end
    end

    // sticky until cnt_rst, set by input or output clipping.
    always_ff @(posedge clk) begin
        if (!rst_n || cnt_rst) begin
            warning <= 1'b0;
        end else if (in_sat || (in_valid && (pow_clip || corr_clip))) begin
            warning <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rfi_detection.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module rfi_detection (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire signed [`RFI_DIN_WIDTH-1:0] sig_re,
    input  wire signed [`RFI_DIN_WIDTH-1:0] sig_im,
    input  wire signed [`RFI_DIN_WIDTH-1:0] ref_re,
    input  wire signed [`RFI_DIN_WIDTH-1:0] ref_im,
    input  wire                             din_valid,
    input  wire                             sync_in,
    input  wire [31:0]                      acc_len,
    input  wire                             cnt_rst,
    output logic [`RFI_DOUT_WIDTH-1:0]      pow_data,
    output logic [`RFI_DOUT_WIDTH-1:0]      corr_data,
    output logic                            dout_valid,
    output logic                            warning
);
    import rfi_pkg::*;

    logic  in_sat;
    logic  prod_valid;
    prod_t prod;
    logic  sum_valid;
    pow_t  pow_sum;
    corr_t corr_sum;

    rfi_stream_if cast_if ();

    rfi_input_cast input_cast (
        .clk       (clk),
        .rst_n     (rst_n),
        .sig_re    (sig_re),
        .sig_im    (sig_im),
        .ref_re    (ref_re),
        .ref_im    (ref_im),
        .din_valid (din_valid),
        .sync_in   (sync_in),
        .out       (cast_if.source),
        .in_sat    (in_sat)
    );

    rfi_product product (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (cast_if.sink),
        .acc_len    (acc_len),
        .cnt_rst    (cnt_rst),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    rfi_vector_acc #(.acc_t(pow_t)) pow_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (prod_valid),
        .chan      (prod.chan),
        .first     (prod.first),
        .last      (prod.last),
        .value     (prod.pow),
        .sum_valid (sum_valid),
        .sum       (pow_sum)
    );

    // same strobe as pow_acc, so its valid stays open.
    rfi_vector_acc #(.acc_t(corr_t)) corr_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (prod_valid),
        .chan      (prod.chan),
        .first     (prod.first),
        .last      (prod.last),
        .value     (prod.corr),
        .sum_valid (),
        .sum       (corr_sum)
    );

    rfi_output_cast output_cast (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_rst    (cnt_rst),
        .in_valid   (sum_valid),
        .pow_sum    (pow_sum),
        .corr_sum   (corr_sum),
        .in_sat     (in_sat),
        .pow_data   (pow_data),
        .corr_data  (corr_data),
        .dout_valid (dout_valid),
        .warning    (warning)
    );

endmodule

`default_nettype wire

// File: rfi_detection_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rfi_detection_sva (
    input wire clk,
    input wire rst_n,
    input wire din_valid,
    input wire cnt_rst,
    input wire dout_valid,
    input wire warning
);

    // count of failed assertions, read at the end of the run.
    int failures;

    initial begin
        failures = 0;
    end

    property quiet_in_reset;
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> (!dout_valid && !warning);
    endproperty

    // cast, product, accumulator and output cast make four stages.
    property valid_latency;
        @(posedge clk) disable iff (!rst_n) dout_valid |-> $past(din_valid, 4);
    endproperty

    property warning_sticky;
        @(posedge clk) disable iff (!rst_n) $fell(warning) |-> $past(cnt_rst);
    endproperty

    assert property (quiet_in_reset) else begin
        failures++;
        $error("dout_valid or warning high while reset is held");
    end

    assert property (valid_latency) else begin
        failures++;
        $error("dout_valid without din_valid four cycles earlier");
    end

    assert property (warning_sticky) else begin
        failures++;
        $error("warning fell without cnt_rst");
    end

endmodule

`default_nettype wire

// File: tb_rfi_detection.sv
`timescale 1ns/1ps
`default_nettype none

`include "rfi_defines.svh"

module tb_rfi_detection;

    typedef logic signed [`RFI_DIN_WIDTH-1:0] din_t;

    localparam int CHANNELS = `RFI_CHANNELS;
    localparam int MAX_SPEC = 128;
    localparam int TIMEOUT = 200;
    localparam int CAST_MAX = (1 << (`RFI_CAST_WIDTH - 1)) - 1;
    localparam int CAST_MIN = -(1 << (`RFI_CAST_WIDTH - 1));
    localparam longint POW_MAX = (longint'(1) << `RFI_DOUT_WIDTH) - 1;
    localparam longint CORR_MAX = (longint'(1) << (`RFI_DOUT_WIDTH - 1)) - 1;
    localparam longint CORR_MIN = -(longint'(1) << (`RFI_DOUT_WIDTH - 1));
    localparam din_t DIN_MAX = din_t'((1 << (`RFI_DIN_WIDTH - 1)) - 1);
    localparam din_t DIN_MIN = din_t'(-(1 << (`RFI_DIN_WIDTH - 1)));

    logic clk, rst_n, din_valid, sync_in, cnt_rst;
    din_t sig_re, sig_im, ref_re, ref_im;
    logic [31:0] acc_len;
    logic [`RFI_DOUT_WIDTH-1:0] pow_data, corr_data;
    logic dout_valid, warning;

    integer seed;
    int errors, checks, out_count, base;
    logic exp_clip;
    din_t lanes [MAX_SPEC][CHANNELS][4];
    logic [`RFI_DOUT_WIDTH-1:0] exp_pow_q [$];
    logic [`RFI_DOUT_WIDTH-1:0] exp_corr_q [$];
    logic [`RFI_DOUT_WIDTH-1:0] exp_pow, exp_corr;

    rfi_detection DUT (.*);

    bind rfi_detection rfi_detection_sva sva_checks (
        .clk(clk), .rst_n(rst_n), .din_valid(din_valid),
        .cnt_rst(cnt_rst), .dout_valid(dout_valid), .warning(warning)
    );

    always #20 clk = ~clk;

    // arithmetic shift, then clip to the cast lane range.
    function automatic int cast_lane(input din_t x);
        int v;
        v = int'(x) >>> `RFI_CAST_SHIFT;
        if (v > CAST_MAX) begin
            v = CAST_MAX;
        end else if (v < CAST_MIN) begin
            v = CAST_MIN;
        end
        return v;
    endfunction

    // expected outputs of one accumulation over n_spec stored spectra.
    function automatic void model_spectra(input int n_spec);
        longint pow_sum;
        longint corr_sum;
        int     cv [4];
        for (int ch = 0; ch < CHANNELS; ch++) begin
            pow_sum = 0;
            corr_sum = 0;
            for (int s = 0; s < n_spec; s++) begin
                for (int k = 0; k < 4; k++) begin
                    cv[k] = cast_lane(lanes[s][ch][k]);
                    if (cv[k] != (int'(lanes[s][ch][k]) >>> `RFI_CAST_SHIFT)) begin
                        exp_clip = 1'b1;
                    end
                end
                pow_sum += cv[2] * cv[2] + cv[3] * cv[3];
                corr_sum += cv[0] * cv[2] + cv[1] * cv[3];
            end
            pow_sum = pow_sum >>> `RFI_DOUT_SHIFT;
            corr_sum = corr_sum >>> `RFI_DOUT_SHIFT;
            if (pow_sum > POW_MAX) begin
                pow_sum = POW_MAX;
                exp_clip = 1'b1;
            end
            if (corr_sum > CORR_MAX || corr_sum < CORR_MIN) begin
                corr_sum = (corr_sum > CORR_MAX) ? CORR_MAX : CORR_MIN;
                exp_clip = 1'b1;
            end
            exp_pow_q.push_back(16'(pow_sum));
            exp_corr_q.push_back(16'(corr_sum));
        end
    endfunction

    // mode 0 is random, 1 sets sig to -ref, 2 puts every lane on a full-scale corner.
    task automatic fill_lanes(input int n_spec, input int span, input int mode);
        for (int s = 0; s < n_spec; s++) begin
            for (int ch = 0; ch < CHANNELS; ch++) begin
                for (int k = 0; k < 4; k++) begin
                    lanes[s][ch][k] = din_t'($random(seed) % span);
                end
                if (mode == 1) begin
                    lanes[s][ch][0] = -lanes[s][ch][2];
                    lanes[s][ch][1] = -lanes[s][ch][3];
                end else if (mode == 2) begin
                    lanes[s][ch][0] = (ch % 2 == 1) ? DIN_MAX : DIN_MIN;
                    lanes[s][ch][1] = lanes[s][ch][0];
                    lanes[s][ch][2] = DIN_MIN;
                    lanes[s][ch][3] = DIN_MIN;
                end
            end
        end
    endtask

    task automatic send_sample(input int s, input int ch, input bit sync);
        @(posedge clk);
        #2;
        din_valid = 1'b1;
        sync_in = sync;
        sig_re = lanes[s][ch][0];
        sig_im = lanes[s][ch][1];
        ref_re = lanes[s][ch][2];
        ref_im = lanes[s][ch][3];
    endtask

    task automatic idle(input int n);
        @(posedge clk);
        #2;
        din_valid = 1'b0;
        sync_in = 1'b0;
        repeat (n - 1) @(posedge clk);
    endtask

    // sync marks channel 0, gaps drop din_valid at random.
    task automatic drive_spectra(input int s_first, input int s_last, input bit gaps);
        for (int s = s_first; s <= s_last; s++) begin
            for (int ch = 0; ch < CHANNELS; ch++) begin
                if (gaps && ($random(seed) % 3 == 0)) begin
                    idle(1);
                end
                send_sample(s, ch, ch == 0);
            end
        end
        idle(1);
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.sva_checks.failures);
        if (errors == 0 && DUT.sva_checks.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic wait_outputs();
        int cycles;
        cycles = 0;
        while (exp_pow_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pow_q.size() != 0) begin
            errors++;
            $display("timeout, %0d results never appeared on dout_valid", exp_pow_q.size());
            exp_pow_q.delete();
            exp_corr_q.delete();
        end
    endtask

    task automatic check_warning();
        @(negedge clk);
        assert (warning === exp_clip) else begin
            errors++;
            $display("ERR warning: got %h, expected %h", warning, exp_clip);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n === 1'b1 && dout_valid === 1'b1) begin
            out_count++;
            assert (exp_pow_q.size() != 0) else begin
                errors++;
                $display("dout_valid was high with no result expected at %0t ns", $time);
            end
            if (exp_pow_q.size() != 0) begin
                exp_pow = exp_pow_q.pop_front();
                exp_corr = exp_corr_q.pop_front();
                checks++;
                assert (pow_data === exp_pow) else begin
                    errors++;
                    $display("ERR pow_data: got %h, expected %h", pow_data, exp_pow);
                end
                assert (corr_data === exp_corr) else begin
                    errors++;
                    $display("ERR corr_data: got %h, expected %h", corr_data, exp_corr);
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        din_valid = 1'b0;
        sync_in = 1'b0;
        cnt_rst = 1'b0;
        sig_re = '0;
        sig_im = '0;
        ref_re = '0;
        ref_im = '0;
        acc_len = 32'd1;
        seed = 32'hb5c7a4ba;
        errors = 0;
        checks = 0;
        out_count = 0;
        exp_clip = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // no sync yet, so these samples must vanish.
        fill_lanes(1, 20000, 0);
        for (int ch = 1; ch < 7; ch++) begin
            send_sample(0, ch, 1'b0);
        end
        idle(12);
        assert (out_count == 0) else begin
            errors++;
            $display("dout_valid appeared for samples sent before any sync");
        end

        // single spectrum.
        fill_lanes(1, 20000, 0);
        model_spectra(1);
        drive_spectra(0, 0, 1'b0);
        wait_outputs();

        // four spectra with gaps, nothing may come out before the fourth.
        acc_len = 32'd4;
        fill_lanes(4, 131072, 0);
        model_spectra(4);
        base = out_count;
        drive_spectra(0, 2, 1'b1);
        idle(8);
        assert (out_count == base) else begin
            errors++;
            $display("dout_valid appeared before the last spectrum of the accumulation");
        end
        drive_spectra(3, 3, 1'b1);
        wait_outputs();

        // opposed signal and reference give a negative correlation.
        acc_len = 32'd2;
        fill_lanes(2, 100000, 1);
        model_spectra(2);
        drive_spectra(0, 1, 1'b0);
        wait_outputs();
        check_warning();

        // full scale over 128 spectra clips both outputs.
        acc_len = 32'd128;
        fill_lanes(128, 1, 2);
        model_spectra(128);
        drive_spectra(0, 127, 1'b0);
        wait_outputs();
        check_warning();
        idle(6);
        check_warning();

        // restart in the middle of a four-spectrum accumulation.
        acc_len = 32'd4;
        fill_lanes(2, 20000, 0);
        drive_spectra(0, 1, 1'b0);
        idle(8);
        @(posedge clk);
        #2;
        cnt_rst = 1'b1;
        @(posedge clk);
        #2;
        cnt_rst = 1'b0;
        exp_clip = 1'b0;
        check_warning();
        for (int ch = 1; ch < 4; ch++) begin
            send_sample(0, ch, 1'b0);
        end
        idle(8);
        acc_len = 32'd2;
        fill_lanes(2, 20000, 0);
        model_spectra(2);
        drive_spectra(0, 1, 1'b1);
        wait_outputs();
        check_warning();

        finish_run();
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
rfi_pkg.sv
rfi_stream_if.sv
rfi_input_cast.sv
rfi_product.sv
rfi_vector_acc.sv
rfi_output_cast.sv
rfi_detection.sv
rfi_detection_sva.sv
tb_rfi_detection.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_rfi_detection --Mdir obj_dir -o tb_rfi_detection

./obj_dir/tb_rfi_detection +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi

exit 0
